// ==== files.f ====
+incdir+include
verilog/tile_pkg.sv
verilog/mem_cmd_router.sv
verilog/cfg_slice.sv
verilog/clint_slice.sv
verilog/io_tile.sv
testbench/io_tile_checker.sv
testbench/tb_io_tile.sv

// ==== include/tile_cfg.svh ====
// Tile memory map and widths
// Shared constants for the memory command path of the tile
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// Datapath widths
`define TILE_ADDR_WIDTH      40
`define TILE_DATA_WIDTH      64
`define TILE_OFFSET_WIDTH    20
`define TILE_DID_WIDTH       3

// Local address map, device field is 4 bits above the offset
`define TILE_LOCAL_LIMIT     32'h8000_0000
`define TILE_DEV_LSB         20
`define TILE_CFG_DEV         4'd1
`define TILE_CLINT_DEV       4'd2
`define TILE_BOOT_PC         40'h00_8000_0000

// Register offsets
`define CFG_FREEZE_OFS       20'h0_0000
`define CFG_NPC_OFS          20'h0_0008
`define CFG_DID_OFS          20'h0_0010
`define CLINT_MSIP_OFS       20'h0_0000
`define CLINT_MTIMECMP_OFS   20'h0_4000
`define CLINT_MTIME_OFS      20'h0_BFF8
`endif

// ==== run.sh ====
#!/bin/sh
# Build the tile testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_io_tile \
  -f files.f -o tb_io_tile || { echo "Build failed"; exit 1; }
out=$(./obj_dir/tb_io_tile)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== testbench/io_tile_checker.sv ====
// Handshake and reset checks for the tile memory command path
// Valid and payload stability on the top-level and slice response links
`timescale 1ns/10ps
`default_nettype none

module io_tile_checker
  (input  logic                clk_i
  , input logic                rst_n_i
  , input tile_pkg::mem_cmd_s  cmd_i
  , input logic                cmd_v_i
  , input logic                cmd_ready_i
  , input logic                resp_v_i
  , input logic                resp_ready_i
  , input tile_pkg::mem_cmd_s  ext_cmd_i
  , input logic                ext_cmd_v_i
  , input logic                ext_cmd_ready_i
  , input tile_pkg::mem_resp_s ext_resp_i
  , input logic                ext_resp_v_i
  , input logic                ext_resp_ready_i
  , input tile_pkg::mem_resp_s cfg_resp_i
  , input logic                cfg_resp_v_i
  , input logic                cfg_resp_ready_i
  , input tile_pkg::mem_resp_s clint_resp_i
  , input logic                clint_resp_v_i
  , input logic                clint_resp_ready_i
  );

  cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_v_i && !cmd_ready_i |=> cmd_v_i && $stable(cmd_i))
    else $error("upstream command changed or dropped before it was accepted");

  ext_cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ext_cmd_v_i && !ext_cmd_ready_i |=> ext_cmd_v_i && $stable(ext_cmd_i))
    else $error("external command changed or dropped before it was accepted");

  ext_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ext_resp_v_i && !ext_resp_ready_i |=> ext_resp_v_i && $stable(ext_resp_i))
    else $error("external response changed or dropped before it was accepted");

  cfg_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_resp_v_i && !cfg_resp_ready_i |=> cfg_resp_v_i && $stable(cfg_resp_i))
    else $error("cfg response changed or dropped before it was accepted");

  clint_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    clint_resp_v_i && !clint_resp_ready_i |=> clint_resp_v_i && $stable(clint_resp_i))
    else $error("interruptor response changed or dropped before it was accepted");

  // Payload may switch when a higher priority source shows up
  resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_v_i && !resp_ready_i |=> resp_v_i)
    else $error("tile response valid dropped before it was accepted");

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !resp_v_i && !ext_cmd_v_i)
    else $error("output valid high during reset");

endmodule

bind io_tile io_tile_checker handshake_chk
  (.clk_i(clk_i), .rst_n_i(rst_n_i)
  , .cmd_i(cmd_i), .cmd_v_i(cmd_v_i), .cmd_ready_i(cmd_ready_o)
  , .resp_v_i(resp_v_o), .resp_ready_i(resp_ready_i)
  , .ext_cmd_i(ext_cmd_o), .ext_cmd_v_i(ext_cmd_v_o), .ext_cmd_ready_i(ext_cmd_ready_i)
  , .ext_resp_i(ext_resp_i), .ext_resp_v_i(ext_resp_v_i)
  , .ext_resp_ready_i(ext_resp_ready_o)
  , .cfg_resp_i(cfg_resp), .cfg_resp_v_i(cfg_resp_v), .cfg_resp_ready_i(cfg_resp_ready)
  , .clint_resp_i(clint_resp), .clint_resp_v_i(clint_resp_v)
  , .clint_resp_ready_i(clint_resp_ready)
  );

`default_nettype wire

// ==== testbench/tb_io_tile.sv ====
// Testbench for the tile memory command path
// Directed tests of the cfg slice, the interruptor, external routing and
// response priority, with a small external memory model
`timescale 1ns/10ps
`default_nettype none

`include "tile_cfg.svh"

module tb_io_tile;

  // About 150 cycles of traffic, the rest is slack for model stalls
  localparam int MAX_CYCLES = 2000;
  localparam logic [39:0] NEW_NPC = 40'h00_4000_1000;

  logic clk, rst_n, cmd_v, cmd_ready, resp_v, resp_ready;
  logic ext_cmd_v, ext_cmd_ready, ext_resp_v, ext_resp_ready;
  logic cfg_freeze, timer_irq, software_irq;
  logic [`TILE_DID_WIDTH-1:0] did;
  logic [`TILE_ADDR_WIDTH-1:0] cfg_npc;
  tile_pkg::mem_cmd_s cmd, ext_cmd, last_ext_cmd;
  tile_pkg::mem_resp_s resp, ext_resp, pend;
  logic [63:0] ext_mem [0:15];
  int model_state, model_wait, err_cnt, chk_cnt, cycle_cnt;

  io_tile DUT
    (.clk_i(clk), .rst_n_i(rst_n), .did_i(did)
    , .cmd_i(cmd), .cmd_v_i(cmd_v), .cmd_ready_o(cmd_ready)
    , .resp_o(resp), .resp_v_o(resp_v), .resp_ready_i(resp_ready)
    , .ext_cmd_o(ext_cmd), .ext_cmd_v_o(ext_cmd_v), .ext_cmd_ready_i(ext_cmd_ready)
    , .ext_resp_i(ext_resp), .ext_resp_v_i(ext_resp_v), .ext_resp_ready_o(ext_resp_ready)
    , .cfg_freeze_o(cfg_freeze), .cfg_npc_o(cfg_npc)
    , .timer_irq_o(timer_irq), .software_irq_o(software_irq)
    );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic [63:0] fill_word(input logic [3:0] idx);
    return {16'hc0de, 12'h000, idx, 16'h5a5a, 12'h000, ~idx};
  endfunction

  function automatic logic [39:0] local_addr(input logic [3:0] dev, input logic [19:0] ofs);
    return {16'h0000, dev, ofs};
  endfunction

  // External memory, one request in flight, 1 to 4 cycles to answer
  always @(posedge clk)
  begin : ext_model
    logic       fire;
    logic       taken;
    logic [3:0] idx;
    fire  = ext_cmd_v && ext_cmd_ready;
    taken = ext_resp_v && ext_resp_ready;
    idx   = ext_cmd.addr.raw[6:3];
    if (fire)
      last_ext_cmd = ext_cmd;
    #1;
    if (!rst_n)
    begin
      model_state = 0;
      ext_cmd_ready = 1'b0;
      ext_resp_v = 1'b0;
    end
    else if (model_state == 0)
    begin
      if (fire)
      begin
        pend.op   = last_ext_cmd.op;
        pend.addr = last_ext_cmd.addr;
        pend.data = ext_mem[idx];
        if (last_ext_cmd.op == tile_pkg::e_mem_wr)
        begin
          ext_mem[idx] = last_ext_cmd.data;
          pend.data = '0;
        end
        model_wait = 1 + ($urandom % 4);
        model_state = 1;
      end
      ext_cmd_ready = !fire && ($urandom % 4 != 0);
    end
    else if (model_state == 1)
    begin
      model_wait--;
      if (model_wait == 0)
      begin
        ext_resp = pend;
        ext_resp_v = 1'b1;
        model_state = 2;
      end
    end
    else if (taken)
    begin
      ext_resp_v = 1'b0;
      model_state = 0;
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed: %0d of %0d", err_cnt, chk_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    chk_cnt++;
    assert (got === exp)
    else
    begin
      err_cnt++;
      $display("Error at time %0d ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Tasks start and end 1 ns after a rising edge
  task automatic send_cmd(input tile_pkg::mem_op_e op, input logic [39:0] addr,
                          input logic [63:0] data);
    cmd.op = op;
    cmd.addr.raw = addr;
    cmd.data = data;
    cmd_v = 1'b1;
    @(posedge clk);
    while (!cmd_ready)
      @(posedge clk);
    #1;
    cmd_v = 1'b0;
  endtask

  task automatic recv_resp(output tile_pkg::mem_resp_s r);
    @(posedge clk);
    while (!(resp_v && resp_ready))
      @(posedge clk);
    r = resp;
    #1;
  endtask

  task automatic do_write(input logic [39:0] addr, input logic [63:0] data);
    tile_pkg::mem_resp_s r;
    send_cmd(tile_pkg::e_mem_wr, addr, data);
    recv_resp(r);
    check_value({62'b0, r.op}, {62'b0, tile_pkg::e_mem_wr}, "write ack opcode");
    check_value({24'b0, r.addr.raw}, {24'b0, addr}, "write ack address");
    check_value(r.data, 64'd0, "write ack data");
  endtask

  task automatic do_read(input logic [39:0] addr, output logic [63:0] data);
    tile_pkg::mem_resp_s r;
    send_cmd(tile_pkg::e_mem_rd, addr, 64'd0);
    recv_resp(r);
    check_value({62'b0, r.op}, {62'b0, tile_pkg::e_mem_rd}, "read response opcode");
    check_value({24'b0, r.addr.raw}, {24'b0, addr}, "read response address");
    data = r.data;
  endtask

  task automatic check_ext_cmd(input tile_pkg::mem_op_e op, input logic [39:0] addr,
                               input logic [63:0] data);
    check_value({62'b0, last_ext_cmd.op}, {62'b0, op}, "external command opcode");
    check_value({24'b0, last_ext_cmd.addr.raw}, {24'b0, addr}, "external command address");
    check_value(last_ext_cmd.data, data, "external command data");
  endtask

  task automatic wait_timer_irq(input logic level, input string what);
    int n;
    n = 0;
    while (timer_irq !== level && n < 4)
    begin
      @(posedge clk);
      #1;
      n++;
    end
    check_value({63'b0, timer_irq}, {63'b0, level}, what);
  endtask

  task automatic test_reset_state();
    check_value({63'b0, cfg_freeze}, 64'd1, "freeze after reset");
    check_value({24'b0, cfg_npc}, {24'b0, `TILE_BOOT_PC}, "boot address after reset");
    check_value({62'b0, timer_irq, software_irq}, 64'd0, "interrupts after reset");
    check_value({62'b0, resp_v, ext_cmd_v}, 64'd0, "output valids after reset");
  endtask

  task automatic test_cfg_regs();
    logic [63:0] rd;
    do_write(local_addr(`TILE_CFG_DEV, `CFG_FREEZE_OFS), 64'd0);
    do_write(local_addr(`TILE_CFG_DEV, `CFG_NPC_OFS), {24'b0, NEW_NPC});
    do_read(local_addr(`TILE_CFG_DEV, `CFG_FREEZE_OFS), rd);
    check_value(rd, 64'd0, "freeze readback");
    do_read(local_addr(`TILE_CFG_DEV, `CFG_NPC_OFS), rd);
    check_value(rd, {24'b0, NEW_NPC}, "boot address readback");
    check_value({63'b0, cfg_freeze}, 64'd0, "freeze output");
    check_value({24'b0, cfg_npc}, {24'b0, NEW_NPC}, "boot address output");
    do_read(local_addr(`TILE_CFG_DEV, `CFG_DID_OFS), rd);
    check_value(rd, {61'b0, did}, "destination ID readback");
    do_read(local_addr(`TILE_CFG_DEV, 20'h0_0018), rd);
    check_value(rd, 64'd0, "unknown cfg offset");
  endtask

  task automatic test_ext_routing();
    logic [63:0] rd;
    // Device fields of the slices above the local limit still go external
    do_write(40'h00_8020_0040, 64'h0123_4567_89ab_cdef);
    check_ext_cmd(tile_pkg::e_mem_wr, 40'h00_8020_0040, 64'h0123_4567_89ab_cdef);
    do_read(40'h00_8020_0040, rd);
    check_ext_cmd(tile_pkg::e_mem_rd, 40'h00_8020_0040, 64'd0);
    check_value(rd, 64'h0123_4567_89ab_cdef, "external readback");
    do_read(40'h01_2310_6788, rd);
    check_ext_cmd(tile_pkg::e_mem_rd, 40'h01_2310_6788, 64'd0);
    check_value(rd, fill_word(4'd1), "external read above local limit");
    // Local address with no device behind its field
    do_read(local_addr(4'd5, 20'h0_0018), rd);
    check_ext_cmd(tile_pkg::e_mem_rd, local_addr(4'd5, 20'h0_0018), 64'd0);
    check_value(rd, fill_word(4'd3), "external read for unknown device");
  endtask

  task automatic test_clint();
    logic [63:0] rd, t1, t2;
    do_write(local_addr(`TILE_CLINT_DEV, `CLINT_MSIP_OFS), 64'd1);
    check_value({63'b0, software_irq}, 64'd1, "software irq set");
    do_read(local_addr(`TILE_CLINT_DEV, `CLINT_MSIP_OFS), rd);
    check_value(rd, 64'd1, "msip readback");
    do_write(local_addr(`TILE_CLINT_DEV, `CLINT_MSIP_OFS), 64'd0);
    check_value({63'b0, software_irq}, 64'd0, "software irq cleared");
    do_read(local_addr(`TILE_CLINT_DEV, `CLINT_MTIME_OFS), t1);
    do_read(local_addr(`TILE_CLINT_DEV, `CLINT_MTIME_OFS), t2);
    check_value({63'b0, t2 > t1}, 64'd1, "mtime increases");
    do_write(local_addr(`TILE_CLINT_DEV, `CLINT_MTIMECMP_OFS), 64'd4);
    wait_timer_irq(1'b1, "timer irq after compare passed");
    do_write(local_addr(`TILE_CLINT_DEV, `CLINT_MTIMECMP_OFS), '1);
    wait_timer_irq(1'b0, "timer irq after compare set to all ones");
  endtask

  task automatic test_backpressure();
    tile_pkg::mem_resp_s first, second;
    resp_ready = 1'b0;
    send_cmd(tile_pkg::e_mem_rd, local_addr(`TILE_CFG_DEV, `CFG_NPC_OFS), 64'd0);
    send_cmd(tile_pkg::e_mem_rd, 40'h00_9000_0010, 64'd0);
    @(posedge clk);
    while (!ext_resp_v)
      @(posedge clk);
    #1;
    resp_ready = 1'b1;
    recv_resp(first);
    recv_resp(second);
    check_value({24'b0, first.addr.raw}, 64'h00_9000_0010, "first response is external");
    check_value(first.data, fill_word(4'd2), "external data under back-pressure");
    check_value({24'b0, second.addr.raw},
                {24'b0, local_addr(`TILE_CFG_DEV, `CFG_NPC_OFS)}, "second response is cfg");
    check_value(second.data, {24'b0, NEW_NPC}, "cfg data under back-pressure");
    @(posedge clk);
    check_value({63'b0, resp_v}, 64'd0, "no extra response");
    #1;
  endtask

  initial
  begin
    void'($urandom(32'h30ddec61));
    err_cnt = 0;
    chk_cnt = 0;
    cycle_cnt = 0;
    rst_n = 1'b0;
    did = 3'd5;
    cmd = '0;
    cmd_v = 1'b0;
    resp_ready = 1'b1;
    ext_cmd_ready = 1'b0;
    ext_resp = '0;
    ext_resp_v = 1'b0;
    last_ext_cmd = '0;
    for (int i = 0; i < 16; i++)
      ext_mem[i] = fill_word(i[3:0]);
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_state();
    test_cfg_regs();
    test_ext_routing();
    test_clint();
    test_backpressure();
    $display("Checks failed: %0d of %0d", err_cnt, chk_cnt);
    if (err_cnt == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cfg_slice.sv ====
// Configuration slice
// Freeze bit, boot address and destination ID readback behind one
// registered response slot
`timescale 1ns/10ps
`default_nettype none

`include "tile_cfg.svh"

module cfg_slice
  (input  logic                        clk_i
  , input  logic                       rst_n_i
  , input  tile_pkg::mem_cmd_s         cmd_i
  , input  logic                       cmd_v_i
  , output logic                       cmd_ready_o
  , output tile_pkg::mem_resp_s        resp_o
  , output logic                       resp_v_o
  , input  logic                       resp_ready_i
  , input  logic [`TILE_DID_WIDTH-1:0] did_i
  , output logic                       cfg_freeze_o
  , output logic [`TILE_ADDR_WIDTH-1:0] cfg_npc_o
  );

  logic                          cmd_fire;
  logic                          is_wr;
  logic [`TILE_OFFSET_WIDTH-1:0] ofs;
  logic [`TILE_DATA_WIDTH-1:0]   rdata;
  logic                          freeze_r;
  logic [`TILE_ADDR_WIDTH-1:0]   npc_r;
  logic                          resp_v_r;
  tile_pkg::mem_resp_s           resp_r;

  // Accept when the slot is empty or draining this cycle
  assign cmd_ready_o = ~resp_v_r | resp_ready_i;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign is_wr       = (cmd_i.op == tile_pkg::e_mem_wr);
  assign ofs         = cmd_i.addr.loc.offset;

  always_comb
  begin
    rdata = '0;
    case (ofs)
      `CFG_FREEZE_OFS: rdata[0] = freeze_r;
      `CFG_NPC_OFS:    rdata[`TILE_ADDR_WIDTH-1:0] = npc_r;
      `CFG_DID_OFS:    rdata[`TILE_DID_WIDTH-1:0] = did_i;
      default:         rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      freeze_r <= 1'b1;
      npc_r    <= `TILE_BOOT_PC;
      resp_v_r <= 1'b0;
    end
    else
    begin
      if (cmd_fire & is_wr & (ofs == `CFG_FREEZE_OFS))
        freeze_r <= cmd_i.data[0];
      if (cmd_fire & is_wr & (ofs == `CFG_NPC_OFS))
        npc_r <= cmd_i.data[`TILE_ADDR_WIDTH-1:0];
      if (cmd_fire)
        resp_v_r <= 1'b1;
      else if (resp_ready_i)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r.op   <= cmd_i.op;
      resp_r.addr <= cmd_i.addr;
      resp_r.data <= is_wr ? '0 : rdata;
    end
  end

  assign resp_o       = resp_r;
  assign resp_v_o     = resp_v_r;
  assign cfg_freeze_o = freeze_r;
  assign cfg_npc_o    = npc_r;

endmodule

`default_nettype wire

// ==== verilog/clint_slice.sv ====
// Core-local interruptor
// Free running mtime, mtimecmp and msip with a registered timer interrupt,
// answering through one response slot
`timescale 1ns/10ps
`default_nettype none

`include "tile_cfg.svh"

module clint_slice
  (input  logic                 clk_i
  , input  logic                rst_n_i
  , input  tile_pkg::mem_cmd_s  cmd_i
  , input  logic                cmd_v_i
  , output logic                cmd_ready_o
  , output tile_pkg::mem_resp_s resp_o
  , output logic                resp_v_o
  , input  logic                resp_ready_i
  , output logic                timer_irq_o
  , output logic                software_irq_o
  );

  logic                          cmd_fire;
  logic                          is_wr;
  logic [`TILE_OFFSET_WIDTH-1:0] ofs;
  logic [`TILE_DATA_WIDTH-1:0]   rdata;
  logic [`TILE_DATA_WIDTH-1:0]   mtime_r;
  logic [`TILE_DATA_WIDTH-1:0]   mtimecmp_r;
  logic                          msip_r;
  logic                          timer_irq_r;
  logic                          resp_v_r;
  tile_pkg::mem_resp_s           resp_r;

  assign cmd_ready_o = ~resp_v_r | resp_ready_i;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign is_wr       = (cmd_i.op == tile_pkg::e_mem_wr);
  assign ofs         = cmd_i.addr.loc.offset;

  always_comb
  begin
    rdata = '0;
    case (ofs)
      `CLINT_MSIP_OFS:     rdata[0] = msip_r;
      `CLINT_MTIMECMP_OFS: rdata = mtimecmp_r;
      `CLINT_MTIME_OFS:    rdata = mtime_r;
      default:             rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mtime_r     <= '0;
      mtimecmp_r  <= '1;
      msip_r      <= 1'b0;
      timer_irq_r <= 1'b0;
      resp_v_r    <= 1'b0;
    end
    else
    begin
      // A write to mtime overrides the count for that cycle
      if (cmd_fire & is_wr & (ofs == `CLINT_MTIME_OFS))
        mtime_r <= cmd_i.data;
      else
        mtime_r <= mtime_r + 1'b1;
      if (cmd_fire & is_wr & (ofs == `CLINT_MTIMECMP_OFS))
        mtimecmp_r <= cmd_i.data;
      if (cmd_fire & is_wr & (ofs == `CLINT_MSIP_OFS))
        msip_r <= cmd_i.data[0];
      timer_irq_r <= (mtime_r >= mtimecmp_r);
      if (cmd_fire)
        resp_v_r <= 1'b1;
      else if (resp_ready_i)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r.op   <= cmd_i.op;
      resp_r.addr <= cmd_i.addr;
      resp_r.data <= is_wr ? '0 : rdata;
    end
  end

  assign resp_o         = resp_r;
  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = timer_irq_r;
  assign software_irq_o = msip_r;

endmodule

`default_nettype wire

// ==== verilog/io_tile.sv ====
// Tile memory command path
// Router plus the configuration and interruptor slices
`timescale 1ns/10ps
`default_nettype none

`include "tile_cfg.svh"

module io_tile
  (input  logic                         clk_i
  , input  logic                        rst_n_i
  , input  logic [`TILE_DID_WIDTH-1:0]  did_i
  , input  tile_pkg::mem_cmd_s          cmd_i
  , input  logic                        cmd_v_i
  , output logic                        cmd_ready_o
  , output tile_pkg::mem_resp_s         resp_o
  , output logic                        resp_v_o
  , input  logic                        resp_ready_i
  , output tile_pkg::mem_cmd_s          ext_cmd_o
  , output logic                        ext_cmd_v_o
  , input  logic                        ext_cmd_ready_i
  , input  tile_pkg::mem_resp_s         ext_resp_i
  , input  logic                        ext_resp_v_i
  , output logic                        ext_resp_ready_o
  , output logic                        cfg_freeze_o
  , output logic [`TILE_ADDR_WIDTH-1:0] cfg_npc_o
  , output logic                        timer_irq_o
  , output logic                        software_irq_o
  );

  tile_pkg::mem_cmd_s  cfg_cmd, clint_cmd;
  logic                cfg_cmd_v, cfg_cmd_ready, clint_cmd_v, clint_cmd_ready;
  tile_pkg::mem_resp_s cfg_resp, clint_resp;
  logic                cfg_resp_v, cfg_resp_ready, clint_resp_v, clint_resp_ready;

  mem_cmd_router router
    (.cmd_i(cmd_i), .cmd_v_i(cmd_v_i), .cmd_ready_o(cmd_ready_o)
    , .resp_o(resp_o), .resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i)
    , .cfg_cmd_o(cfg_cmd), .cfg_cmd_v_o(cfg_cmd_v), .cfg_cmd_ready_i(cfg_cmd_ready)
    , .clint_cmd_o(clint_cmd), .clint_cmd_v_o(clint_cmd_v)
    , .clint_cmd_ready_i(clint_cmd_ready)
    , .ext_cmd_o(ext_cmd_o), .ext_cmd_v_o(ext_cmd_v_o), .ext_cmd_ready_i(ext_cmd_ready_i)
    , .cfg_resp_i(cfg_resp), .cfg_resp_v_i(cfg_resp_v), .cfg_resp_ready_o(cfg_resp_ready)
    , .clint_resp_i(clint_resp), .clint_resp_v_i(clint_resp_v)
    , .clint_resp_ready_o(clint_resp_ready)
    , .ext_resp_i(ext_resp_i), .ext_resp_v_i(ext_resp_v_i)
    , .ext_resp_ready_o(ext_resp_ready_o)
    );

  cfg_slice cfg
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
    , .cmd_i(cfg_cmd), .cmd_v_i(cfg_cmd_v), .cmd_ready_o(cfg_cmd_ready)
    , .resp_o(cfg_resp), .resp_v_o(cfg_resp_v), .resp_ready_i(cfg_resp_ready)
    , .did_i(did_i), .cfg_freeze_o(cfg_freeze_o), .cfg_npc_o(cfg_npc_o)
    );

  clint_slice clint
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
    , .cmd_i(clint_cmd), .cmd_v_i(clint_cmd_v), .cmd_ready_o(clint_cmd_ready)
    , .resp_o(clint_resp), .resp_v_o(clint_resp_v), .resp_ready_i(clint_resp_ready)
    , .timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o)
    );

endmodule

`default_nettype wire

// ==== verilog/mem_cmd_router.sv ====
// Memory command router
// Steers commands to the cfg slice, the CLINT or external memory by address
// and merges the three response streams with a fixed priority arbiter
`timescale 1ns/10ps
`default_nettype none

`include "tile_cfg.svh"

module mem_cmd_router
  (input  tile_pkg::mem_cmd_s  cmd_i
  , input  logic               cmd_v_i
  , output logic               cmd_ready_o

  , output tile_pkg::mem_resp_s resp_o
  , output logic               resp_v_o
  , input  logic               resp_ready_i

  , output tile_pkg::mem_cmd_s cfg_cmd_o
  , output logic               cfg_cmd_v_o
  , input  logic               cfg_cmd_ready_i

  , output tile_pkg::mem_cmd_s clint_cmd_o
  , output logic               clint_cmd_v_o
  , input  logic               clint_cmd_ready_i

  , output tile_pkg::mem_cmd_s ext_cmd_o
  , output logic               ext_cmd_v_o
  , input  logic               ext_cmd_ready_i

  , input  tile_pkg::mem_resp_s cfg_resp_i
  , input  logic               cfg_resp_v_i
  , output logic               cfg_resp_ready_o

  , input  tile_pkg::mem_resp_s clint_resp_i
  , input  logic               clint_resp_v_i
  , output logic               clint_resp_ready_o

  , input  tile_pkg::mem_resp_s ext_resp_i
  , input  logic               ext_resp_v_i
  , output logic               ext_resp_ready_o
  );

  logic is_local;
  logic to_cfg;
  logic to_clint;
  logic to_ext;

  // Decode through the device view of the address
  assign is_local = (cmd_i.addr.raw < `TILE_LOCAL_LIMIT);
  assign to_cfg   = is_local & (cmd_i.addr.loc.dev == `TILE_CFG_DEV);
  assign to_clint = is_local & (cmd_i.addr.loc.dev == `TILE_CLINT_DEV);
  assign to_ext   = ~to_cfg & ~to_clint;

  assign cfg_cmd_o     = cmd_i;
  assign clint_cmd_o   = cmd_i;
  assign ext_cmd_o     = cmd_i;
  assign cfg_cmd_v_o   = cmd_v_i & to_cfg;
  assign clint_cmd_v_o = cmd_v_i & to_clint;
  assign ext_cmd_v_o   = cmd_v_i & to_ext;

  assign cmd_ready_o = to_cfg   ? cfg_cmd_ready_i
                     : to_clint ? clint_cmd_ready_i
                     : ext_cmd_ready_i;

  // External wins, then cfg, then clint
  assign resp_v_o = ext_resp_v_i | cfg_resp_v_i | clint_resp_v_i;
  assign resp_o   = ext_resp_v_i ? ext_resp_i
                  : cfg_resp_v_i ? cfg_resp_i
                  : clint_resp_i;

  assign ext_resp_ready_o   = resp_ready_i;
  assign cfg_resp_ready_o   = resp_ready_i & ~ext_resp_v_i;
  assign clint_resp_ready_o = resp_ready_i & ~ext_resp_v_i & ~cfg_resp_v_i;

endmodule

`default_nettype wire

// ==== verilog/tile_pkg.sv ====
// Tile memory message types
// Opcodes, address views and command/response payloads
`default_nettype none

`include "tile_cfg.svh"

package tile_pkg;

  typedef enum logic [1:0] {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } mem_op_e;

  // Local device view of an address
  typedef struct packed {
    logic [`TILE_ADDR_WIDTH-`TILE_DEV_LSB-5:0] upper;
    logic [3:0]                                dev;
    logic [`TILE_OFFSET_WIDTH-1:0]             offset;
  } local_addr_s;

  typedef union packed {
    logic [`TILE_ADDR_WIDTH-1:0] raw;
    local_addr_s                 loc;
  } tile_addr_u;

  typedef struct packed {
    mem_op_e                     op;
    tile_addr_u                  addr;
    logic [`TILE_DATA_WIDTH-1:0] data;
  } mem_cmd_s;

  // Data is zero for write acks
  typedef struct packed {
    mem_op_e                     op;
    tile_addr_u                  addr;
    logic [`TILE_DATA_WIDTH-1:0] data;
  } mem_resp_s;

endpackage

`default_nettype wire
